// ==== files.f ====
+incdir+include
+incdir+bench
logic/ising_pkg.sv
logic/lagd_fifo_v3.sv
logic/spin_fifo_maintainer.sv
logic/coupling_energy_unit.sv
logic/bias_energy_unit.sv
logic/energy_tracker.sv
logic/ising_energy_top.sv
bench/ising_energy_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail status
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module ising_energy_tb -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vising_energy_tb > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation reported no failure"
exit 0

// ==== bench/ising_energy_model.svh ====
`ifndef ISING_ENERGY_MODEL_SVH
`define ISING_ENERGY_MODEL_SVH

// Reference model, included inside the testbench module
// Reads the shadow copies j_shadow and h_shadow declared there

// Lexicographic number of pair (i,j) with i<j
function automatic int pair_index(input int i, input int j);
    return i * (`ISING_NUM_SPIN - 1) - (i * (i - 1)) / 2 + (j - i - 1);
endfunction

// Bit 1 is spin +1, bit 0 is spin -1
function automatic int spin_value(input spin_vec_t s, input int i);
    return s[i] ? 1 : -1;
endfunction

// E = -(sum J_ij*s_i*s_j + sum h_i*s_i)
function automatic int ref_energy(input spin_vec_t s);
    int sum;
    sum = 0;
    for (int i = 0; i < `ISING_NUM_SPIN - 1; i++) begin
        for (int j = i + 1; j < `ISING_NUM_SPIN; j++) begin
            sum += int'(j_shadow[pair_index(i, j)]) * spin_value(s, i) * spin_value(s, j);
        end
    end
    for (int i = 0; i < `ISING_NUM_SPIN; i++) begin
        sum += int'(h_shadow[i]) * spin_value(s, i);
    end
    return -sum;
endfunction

// Pop gating of the maintainer, ready not included
function automatic bit ref_pop_allowed(input logic en, input logic empty, input logic busy,
                                       input logic finish, input logic readout);
    return en && !empty && ((busy && !finish) || readout);
endfunction

`endif

// ==== bench/ising_energy_tb.sv ====
`timescale 1ns/1ps
`include "ising_defines.svh"

module ising_energy_tb import ising_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_VEC      = 32;
    localparam int FIFO_DEPTH   = `ISING_SPIN_DEPTH;
    localparam int ENERGY_MAX   = (1 << (`ISING_ENERGY_W - 1)) - 1;
    localparam int WAIT_LIMIT   = 100;
    // Reset, two coefficient loads with busy pulses, pushes at about half rate, drains
    localparam int STIM_CYCLES  = RESET_CYCLES + 2 * (`ISING_NUM_PAIR + 4) + 4 * NUM_VEC + 64;
    localparam int WATCHDOG_NS  = (STIM_CYCLES + 200) * CLK_PERIOD;

    logic        clk_i;
    logic        reset_i;
    logic        en_i;
    logic        flush_i;
    logic        cmpt_en_i;
    logic        host_readout_i;
    logic        icon_finish_i;
    logic        spin_push_valid_i;
    spin_vec_t   spin_push_i;
    logic        energy_ready_i;
    logic        j_we_i;
    pair_idx_t   j_addr_i;
    coef_t       j_data_i;
    logic        h_we_i;
    spin_idx_t   h_addr_i;
    coef_t       h_data_i;
    logic        spin_push_ready_o;
    logic        cmpt_busy_o;
    fifo_usage_t debug_fifo_usage_o;
    logic        energy_valid_o;
    energy_t     energy_o;
    energy_t     best_energy_o;
    spin_vec_t   best_spin_o;

    // Shadow state of the model
    coef_t     j_shadow [`ISING_NUM_PAIR];
    coef_t     h_shadow [`ISING_NUM_SPIN];
    spin_vec_t fifo_shadow [$];
    logic      busy_shadow;

    // Pops still waiting for their energy
    int        exp_energy_q [$];
    int        exp_cycle_q [$];
    spin_vec_t exp_spin_q [$];

    int        cycle_cnt = 0;
    int        n_energy = 0;
    int        ref_best = ENERGY_MAX;
    spin_vec_t ref_best_spin = '0;
    int        error_cnt = 0;
    int        test_err_start = 0;
    int        n_pass = 0;
    int        n_fail = 0;
    string     test_name = "reset";
    bit        toggle_on;

    `include "ising_energy_model.svh"

    ising_energy_top ising_energy_top_i (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .en_i              (en_i),
        .flush_i           (flush_i),
        .cmpt_en_i         (cmpt_en_i),
        .host_readout_i    (host_readout_i),
        .icon_finish_i     (icon_finish_i),
        .spin_push_valid_i (spin_push_valid_i),
        .spin_push_i       (spin_push_i),
        .energy_ready_i    (energy_ready_i),
        .j_we_i            (j_we_i),
        .j_addr_i          (j_addr_i),
        .j_data_i          (j_data_i),
        .h_we_i            (h_we_i),
        .h_addr_i          (h_addr_i),
        .h_data_i          (h_data_i),
        .spin_push_ready_o (spin_push_ready_o),
        .cmpt_busy_o       (cmpt_busy_o),
        .debug_fifo_usage_o(debug_fifo_usage_o),
        .energy_valid_o    (energy_valid_o),
        .energy_o          (energy_o),
        .best_energy_o     (best_energy_o),
        .best_spin_o       (best_spin_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Cycle number as read at the falling edge where checks run
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic report_mismatch(input string what, input int exp_v, input int act_v);
        $display("ERROR %s: %s expected %0d actual %0d", test_name, what, exp_v, act_v);
        error_cnt++;
    endtask

    task automatic report_problem(input string what);
        $display("Problem in test %s: %s", test_name, what);
        error_cnt++;
    endtask

    task automatic check_value(input string what, input int exp_v, input int act_v);
        assert (act_v == exp_v) else report_mismatch(what, exp_v, act_v);
    endtask

    // Shadow FIFO, status and coefficients follow the DUT edge by edge
    always @(negedge clk_i) begin : fifo_monitor
        int   level;
        logic exp_ready;
        logic pop_now;
        if (reset_i) begin
            fifo_shadow.delete();
            exp_energy_q.delete();
            exp_cycle_q.delete();
            exp_spin_q.delete();
            busy_shadow = 1'b0;
            for (int p = 0; p < `ISING_NUM_PAIR; p++) j_shadow[p] = '0;
            for (int i = 0; i < `ISING_NUM_SPIN; i++) h_shadow[i] = '0;
        end else begin
            level     = fifo_shadow.size();
            exp_ready = en_i && (level < FIFO_DEPTH);
            assert (int'(debug_fifo_usage_o) == level)
                else report_mismatch("debug_fifo_usage_o", level, int'(debug_fifo_usage_o));
            assert (spin_push_ready_o == exp_ready)
                else report_mismatch("spin_push_ready_o", exp_ready, spin_push_ready_o);
            assert (cmpt_busy_o == busy_shadow)
                else report_mismatch("cmpt_busy_o", busy_shadow, cmpt_busy_o);
            // Sums of a pop use the coefficients from before this cycle's writes
            pop_now = ref_pop_allowed(en_i, level == 0, busy_shadow, icon_finish_i,
                                      host_readout_i) && energy_ready_i;
            if (pop_now) begin
                exp_energy_q.push_back(ref_energy(fifo_shadow[0]));
                exp_cycle_q.push_back(cycle_cnt + 2);
                exp_spin_q.push_back(fifo_shadow.pop_front());
            end
            if (spin_push_valid_i && exp_ready) fifo_shadow.push_back(spin_push_i);
            // Clear beats set
            if ((icon_finish_i && level == FIFO_DEPTH) || flush_i) begin
                busy_shadow = 1'b0;
            end else if (cmpt_en_i && en_i) begin
                busy_shadow = 1'b1;
            end
            if (flush_i) fifo_shadow.delete();
            if (j_we_i && (int'(j_addr_i) < `ISING_NUM_PAIR)) j_shadow[j_addr_i] = j_data_i;
            if (h_we_i) h_shadow[h_addr_i] = h_data_i;
        end
    end

    // Each pop owes exactly one energy_valid_o two cycles later
    always @(negedge clk_i) begin : energy_compare
        int        exp_e;
        spin_vec_t exp_s;
        logic      due;
        if (reset_i) begin
            ref_best      = ENERGY_MAX;
            ref_best_spin = '0;
        end else begin
            due = (exp_cycle_q.size() != 0) && (exp_cycle_q[0] == cycle_cnt);
            if (due) begin
                exp_e = exp_energy_q.pop_front();
                exp_s = exp_spin_q.pop_front();
                void'(exp_cycle_q.pop_front());
                assert (energy_valid_o)
                    else report_problem("energy_valid_o missing two cycles after a pop");
                if (energy_valid_o) begin
                    assert (int'(energy_o) == exp_e)
                        else report_mismatch("energy_o", exp_e, int'(energy_o));
                    n_energy++;
                end
                // Only a strictly lower energy replaces the first vector at the minimum
                if (exp_e < ref_best) begin
                    ref_best      = exp_e;
                    ref_best_spin = exp_s;
                end
            end else begin
                assert (!energy_valid_o)
                    else report_problem("energy_valid_o without a pop two cycles earlier");
            end
            if (flush_i) begin
                ref_best      = ENERGY_MAX;
                ref_best_spin = '0;
            end
        end
    end

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = error_cnt;
    endtask

    task automatic end_test();
        if (error_cnt == test_err_start) begin
            $display("test %s passed", test_name);
            n_pass++;
        end else begin
            $display("test %s failed with %0d errors", test_name, error_cnt - test_err_start);
            n_fail++;
        end
    endtask

    // Every J plus h alongside in the first 8 writes
    task automatic write_random_coefs();
        for (int p = 0; p < `ISING_NUM_PAIR; p++) begin
            @(posedge clk_i);
            j_we_i   <= 1'b1;
            j_addr_i <= pair_idx_t'(p);
            j_data_i <= coef_t'($urandom);
            h_we_i   <= (p < `ISING_NUM_SPIN);
            h_addr_i <= spin_idx_t'(p);
            h_data_i <= coef_t'($urandom);
        end
        @(posedge clk_i);
        j_we_i <= 1'b0;
        h_we_i <= 1'b0;
    endtask

    task automatic pulse_cmpt_en();
        @(posedge clk_i);
        cmpt_en_i <= 1'b1;
        @(posedge clk_i);
        cmpt_en_i <= 1'b0;
    endtask

    task automatic pulse_finish();
        @(posedge clk_i);
        icon_finish_i <= 1'b1;
        @(posedge clk_i);
        icon_finish_i <= 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
    endtask

    // Returns once ready is seen and the push lands on the next rising edge
    task automatic push_vector(input spin_vec_t v);
        int waited;
        waited = 0;
        @(posedge clk_i);
        spin_push_valid_i <= 1'b1;
        spin_push_i       <= v;
        @(negedge clk_i);
        while (!spin_push_ready_o && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        assert (spin_push_ready_o) else report_problem("spin push was never accepted");
    endtask

    task automatic stop_push();
        @(posedge clk_i);
        spin_push_valid_i <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((fifo_shadow.size() != 0 || exp_energy_q.size() != 0) && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        assert (fifo_shadow.size() == 0 && exp_energy_q.size() == 0)
            else report_problem("FIFO and energy pipeline did not drain in time");
        @(posedge clk_i);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns in test %s", WATCHDOG_NS, test_name);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : stimulus
        int        start_cnt;
        spin_vec_t next_vec;
        void'($urandom(32'h809));
        reset_i           = 1'b1;
        en_i              = 1'b0;
        flush_i           = 1'b0;
        cmpt_en_i         = 1'b0;
        host_readout_i    = 1'b0;
        icon_finish_i     = 1'b0;
        spin_push_valid_i = 1'b0;
        spin_push_i       = '0;
        energy_ready_i    = 1'b0;
        j_we_i            = 1'b0;
        j_addr_i          = '0;
        j_data_i          = '0;
        h_we_i            = 1'b0;
        h_addr_i          = '0;
        h_data_i          = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_i        <= 1'b0;
        en_i           <= 1'b1;
        energy_ready_i <= 1'b1;

        // Random coefficients and busy pops with a fixed two cycle latency
        begin_test("random_energy");
        write_random_coefs();
        pulse_cmpt_en();
        for (int k = 0; k < NUM_VEC; k++) push_vector(spin_vec_t'($urandom));
        stop_push();
        wait_drain();
        end_test();

        // Idle status holds everything in the FIFO until host readout
        begin_test("pop_gating");
        pulse_flush();
        start_cnt = n_energy;
        for (int k = 0; k < FIFO_DEPTH; k++) push_vector(spin_vec_t'($urandom));
        @(posedge clk_i);
        spin_push_i <= spin_vec_t'($urandom);
        repeat (3) begin
            @(negedge clk_i);
            check_value("spin_push_ready_o when full", 0, spin_push_ready_o);
            check_value("debug_fifo_usage_o when full", FIFO_DEPTH, debug_fifo_usage_o);
        end
        @(posedge clk_i);
        spin_push_valid_i <= 1'b0;
        host_readout_i    <= 1'b1;
        wait_drain();
        host_readout_i <= 1'b0;
        check_value("energies after readout", FIFO_DEPTH, n_energy - start_cnt);
        end_test();

        // Set, finish while not full, finish while full, flush
        begin_test("completion_status");
        energy_ready_i <= 1'b0;
        pulse_cmpt_en();
        @(negedge clk_i);
        check_value("cmpt_busy_o after cmpt_en_i", 1, cmpt_busy_o);
        pulse_finish();
        @(negedge clk_i);
        check_value("cmpt_busy_o after finish with FIFO not full", 1, cmpt_busy_o);
        for (int k = 0; k < FIFO_DEPTH; k++) push_vector(spin_vec_t'($urandom));
        stop_push();
        pulse_finish();
        @(negedge clk_i);
        check_value("cmpt_busy_o after finish with FIFO full", 0, cmpt_busy_o);
        check_value("debug_fifo_usage_o after finish", FIFO_DEPTH, debug_fifo_usage_o);
        pulse_cmpt_en();
        // Flush and cmpt_en_i together leave the status clear
        @(posedge clk_i);
        flush_i   <= 1'b1;
        cmpt_en_i <= 1'b1;
        @(posedge clk_i);
        flush_i   <= 1'b0;
        cmpt_en_i <= 1'b0;
        @(negedge clk_i);
        check_value("cmpt_busy_o after flush", 0, cmpt_busy_o);
        check_value("debug_fifo_usage_o after flush", 0, debug_fifo_usage_o);
        @(posedge clk_i);
        energy_ready_i <= 1'b1;
        end_test();

        // Random ready and push gaps still give one energy per vector in order
        begin_test("back_pressure");
        pulse_cmpt_en();
        start_cnt = n_energy;
        toggle_on = 1'b1;
        fork
            begin
                for (int k = 0; k < NUM_VEC; k++) begin
                    next_vec = spin_vec_t'($urandom);
                    if ($urandom % 4 == 0) stop_push();
                    push_vector(next_vec);
                end
                stop_push();
                // Ready driver stops at the following rising edge
                @(negedge clk_i);
                toggle_on = 1'b0;
            end
            begin
                while (toggle_on) begin
                    @(posedge clk_i);
                    energy_ready_i <= 1'($urandom % 2);
                end
            end
        join
        @(posedge clk_i);
        energy_ready_i <= 1'b1;
        wait_drain();
        check_value("energies under back-pressure", NUM_VEC, n_energy - start_cnt);
        end_test();

        // Running minimum over one run and back to the maximum on flush
        begin_test("min_tracking");
        pulse_flush();
        write_random_coefs();
        pulse_cmpt_en();
        for (int k = 0; k < NUM_VEC; k++) push_vector(spin_vec_t'($urandom));
        stop_push();
        wait_drain();
        @(negedge clk_i);
        check_value("best_energy_o", ref_best, int'(best_energy_o));
        check_value("best_spin_o", ref_best_spin, best_spin_o);
        pulse_flush();
        @(negedge clk_i);
        check_value("best_energy_o after flush", ENERGY_MAX, int'(best_energy_o));
        check_value("best_spin_o after flush", 0, best_spin_o);
        end_test();

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/ising_energy_top.sv ====
`timescale 1ns/1ps

module ising_energy_top import ising_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        en_i,
    input  logic        flush_i,
    input  logic        cmpt_en_i,
    input  logic        host_readout_i,
    input  logic        icon_finish_i,
    input  logic        spin_push_valid_i,
    input  spin_vec_t   spin_push_i,
    input  logic        energy_ready_i,
    input  logic        j_we_i,
    input  pair_idx_t   j_addr_i,
    input  coef_t       j_data_i,
    input  logic        h_we_i,
    input  spin_idx_t   h_addr_i,
    input  coef_t       h_data_i,
    output logic        spin_push_ready_o,
    output logic        cmpt_busy_o,
    output fifo_usage_t debug_fifo_usage_o,
    output logic        energy_valid_o,
    output energy_t     energy_o,
    output energy_t     best_energy_o,
    output spin_vec_t   best_spin_o
);

    // Pop pulse and FIFO head, broadcast to both units
    logic      spin_pop_fire;
    spin_vec_t spin_pop;

    logic      coupling_valid;
    energy_t   coupling_sum;
    logic      bias_valid;
    energy_t   bias_sum;

    // Pop valid stays internal, only the fire pulse leaves
    spin_fifo_maintainer spin_fifo_maintainer_i (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .en_i              (en_i),
        .flush_i           (flush_i),
        .cmpt_en_i         (cmpt_en_i),
        .host_readout_i    (host_readout_i),
        .icon_finish_i     (icon_finish_i),
        .spin_push_valid_i (spin_push_valid_i),
        .spin_push_i       (spin_push_i),
        .spin_pop_ready_i  (energy_ready_i),
        .spin_push_ready_o (spin_push_ready_o),
        .spin_pop_valid_o  (),
        .spin_pop_fire_o   (spin_pop_fire),
        .spin_pop_o        (spin_pop),
        .cmpt_busy_o       (cmpt_busy_o),
        .debug_fifo_usage_o(debug_fifo_usage_o)
    );

    coupling_energy_unit coupling_energy_unit_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .j_we_i          (j_we_i),
        .j_addr_i        (j_addr_i),
        .j_data_i        (j_data_i),
        .spin_valid_i    (spin_pop_fire),
        .spin_i          (spin_pop),
        .coupling_valid_o(coupling_valid),
        .coupling_sum_o  (coupling_sum)
    );

    bias_energy_unit bias_energy_unit_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .h_we_i      (h_we_i),
        .h_addr_i    (h_addr_i),
        .h_data_i    (h_data_i),
        .spin_valid_i(spin_pop_fire),
        .spin_i      (spin_pop),
        .bias_valid_o(bias_valid),
        .bias_sum_o  (bias_sum)
    );

    energy_tracker energy_tracker_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .coupling_valid_i(coupling_valid),
        .coupling_sum_i  (coupling_sum),
        .bias_valid_i    (bias_valid),
        .bias_sum_i      (bias_sum),
        .spin_i          (spin_pop),
        .energy_valid_o  (energy_valid_o),
        .energy_o        (energy_o),
        .best_energy_o   (best_energy_o),
        .best_spin_o     (best_spin_o)
    );

endmodule

// ==== logic/energy_tracker.sv ====
`timescale 1ns/1ps
`include "ising_defines.svh"

module energy_tracker import ising_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      flush_i,
    input  logic      coupling_valid_i,
    input  energy_t   coupling_sum_i,
    input  logic      bias_valid_i,
    input  energy_t   bias_sum_i,
    input  spin_vec_t spin_i,
    output logic      energy_valid_o,
    output energy_t   energy_o,
    output energy_t   best_energy_o,
    output spin_vec_t best_spin_o
);

    // Largest positive energy, start value of the running minimum
    localparam energy_t ENERGY_MAX = {1'b0, {(`ISING_ENERGY_W-1){1'b1}}};

    spin_vec_t spin_d_q;
    energy_t   energy_d;
    energy_t   energy_q;
    energy_t   best_energy_q;
    spin_vec_t best_spin_q;
    logic      energy_valid_q;
    logic      stage_en;

    // FIFO head one cycle late lines up with the registered sums
    always_ff @(posedge clk_i) begin
        spin_d_q <= spin_i;
    end

    // Both units must agree that a result is present
    assign stage_en = coupling_valid_i & bias_valid_i;

    // E = -(coupling + bias)
    assign energy_d = -(coupling_sum_i + bias_sum_i);

    always_ff @(posedge clk_i) begin
        if (stage_en) begin
            energy_q <= energy_d;
        end
    end

    // Running minimum, ties keep the earlier vector
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            energy_valid_q <= 1'b0;
            best_energy_q  <= ENERGY_MAX;
            best_spin_q    <= '0;
        end else begin
            energy_valid_q <= stage_en;
            if (stage_en && (energy_d < best_energy_q)) begin
                best_energy_q <= energy_d;
                best_spin_q   <= spin_d_q;
            end
        end
    end

    assign energy_valid_o = energy_valid_q;
    assign energy_o       = energy_q;
    assign best_energy_o  = best_energy_q;
    assign best_spin_o    = best_spin_q;

endmodule

// ==== logic/bias_energy_unit.sv ====
`timescale 1ns/1ps
`include "ising_defines.svh"

module bias_energy_unit import ising_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      h_we_i,
    input  spin_idx_t h_addr_i,
    input  coef_t     h_data_i,
    input  logic      spin_valid_i,
    input  spin_vec_t spin_i,
    output logic      bias_valid_o,
    output energy_t   bias_sum_o
);

    // One h per spin
    coef_t   h_q [`ISING_NUM_SPIN];
    energy_t sum_d;
    energy_t sum_q;
    logic    valid_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `ISING_NUM_SPIN; i++) begin
                h_q[i] <= '0;
            end
        end else if (h_we_i) begin
            h_q[h_addr_i] <= h_data_i;
        end
    end

    // Spin +1 adds h, spin -1 subtracts it
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < `ISING_NUM_SPIN; i++) begin
            if (spin_i[i]) begin
                sum_d = sum_d + energy_t'(h_q[i]);
            end else begin
                sum_d = sum_d - energy_t'(h_q[i]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_valid_i) begin
            sum_q <= sum_d;
        end
    end

    // Valid follows the pop by one cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= spin_valid_i;
        end
    end

    assign bias_valid_o = valid_q;
    assign bias_sum_o   = sum_q;

endmodule

// ==== logic/coupling_energy_unit.sv ====
`timescale 1ns/1ps
`include "ising_defines.svh"

module coupling_energy_unit import ising_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      j_we_i,
    input  pair_idx_t j_addr_i,
    input  coef_t     j_data_i,
    input  logic      spin_valid_i,
    input  spin_vec_t spin_i,
    output logic      coupling_valid_o,
    output energy_t   coupling_sum_o
);

    // One J per pair, lexicographic pair order
    coef_t   j_q [`ISING_NUM_PAIR];
    energy_t sum_d;
    energy_t sum_q;
    logic    valid_q;

    // Host writes, addresses past the last pair are ignored
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int p = 0; p < `ISING_NUM_PAIR; p++) begin
                j_q[p] <= '0;
            end
        end else if (j_we_i && (j_addr_i < pair_idx_t'(`ISING_NUM_PAIR))) begin
            j_q[j_addr_i] <= j_data_i;
        end
    end

    // Pairwise sum of J*s_i*s_j
    // Equal spins give +J, differing spins give -J
    always_comb begin
        int p;
        p     = 0;
        sum_d = '0;
        for (int i = 0; i < `ISING_NUM_SPIN - 1; i++) begin
            for (int j = i + 1; j < `ISING_NUM_SPIN; j++) begin
                if (spin_i[i] == spin_i[j]) begin
                    sum_d = sum_d + energy_t'(j_q[p]);
                end else begin
                    sum_d = sum_d - energy_t'(j_q[p]);
                end
                p = p + 1;
            end
        end
    end

    // Sum is payload, only the valid pulse is reset
    always_ff @(posedge clk_i) begin
        if (spin_valid_i) begin
            sum_q <= sum_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= spin_valid_i;
        end
    end

    assign coupling_valid_o = valid_q;
    assign coupling_sum_o   = sum_q;

endmodule

// ==== logic/spin_fifo_maintainer.sv ====
`timescale 1ns/1ps
`include "ising_defines.svh"

module spin_fifo_maintainer import ising_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        en_i,
    input  logic        flush_i,
    input  logic        cmpt_en_i,
    input  logic        host_readout_i,
    input  logic        icon_finish_i,
    input  logic        spin_push_valid_i,
    input  spin_vec_t   spin_push_i,
    input  logic        spin_pop_ready_i,
    output logic        spin_push_ready_o,
    output logic        spin_pop_valid_o,
    output logic        spin_pop_fire_o,
    output spin_vec_t   spin_pop_o,
    output logic        cmpt_busy_o,
    output fifo_usage_t debug_fifo_usage_o
);

    logic fifo_full;
    logic fifo_empty;
    logic fifo_push;
    logic cmpt_busy_q;
    logic cmpt_set;
    logic cmpt_clr;

    lagd_fifo_v3 #(
        .DATA_WIDTH(`ISING_NUM_SPIN),
        .DEPTH     (`ISING_SPIN_DEPTH)
    ) spin_fifo_i (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .flush_i(flush_i),
        .push_i (fifo_push),
        .data_i (spin_push_i),
        .pop_i  (spin_pop_fire_o),
        .full_o (fifo_full),
        .empty_o(fifo_empty),
        .usage_o(debug_fifo_usage_o),
        .data_o (spin_pop_o)
    );

    // Push side, accept while enabled and not full
    assign spin_push_ready_o = en_i & ~fifo_full;
    assign fifo_push         = spin_push_valid_i & spin_push_ready_o;

    // Pop side
    // Busy status lets pops through unless the solver is finishing,
    // host readout overrides the status entirely
    assign spin_pop_valid_o = en_i & ~fifo_empty &
                              ((cmpt_busy_q & ~icon_finish_i) | host_readout_i);
    assign spin_pop_fire_o  = spin_pop_valid_o & spin_pop_ready_i;

    // Completion status set and clear terms
    assign cmpt_set = cmpt_en_i & en_i;
    assign cmpt_clr = (icon_finish_i & fifo_full) | flush_i;

    // Clear has priority over set
    always_ff @(posedge clk_i) begin
        if (reset_i || cmpt_clr) begin
            cmpt_busy_q <= 1'b0;
        end else if (cmpt_set) begin
            cmpt_busy_q <= 1'b1;
        end
    end

    assign cmpt_busy_o = cmpt_busy_q;

endmodule

// ==== logic/lagd_fifo_v3.sv ====
`timescale 1ns/1ps

module lagd_fifo_v3 import ising_pkg::*; #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 4
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  flush_i,
    input  logic                  push_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  pop_i,
    output logic                  full_o,
    output logic                  empty_o,
    output fifo_usage_t           usage_o,
    output logic [DATA_WIDTH-1:0] data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Storage, no reset on the payload
    logic [DATA_WIDTH-1:0] mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    fifo_usage_t      count_q;
    logic             push_ok;
    logic             pop_ok;

    // Writes into a full FIFO and reads from an empty one are dropped
    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;

    assign full_o  = (count_q == fifo_usage_t'(DEPTH));
    assign empty_o = (count_q == '0);
    assign usage_o = count_q;

    // Head entry, registered storage so nothing falls through
    assign data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Pointers wrap at DEPTH-1, which need not be a power of two
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (pop_ok) begin
                if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            // Count moves only when exactly one side fires
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== logic/ising_pkg.sv ====
`include "ising_defines.svh"

package ising_pkg;

    // One bit per spin, 1 is +1 and 0 is -1
    typedef logic [`ISING_NUM_SPIN-1:0] spin_vec_t;

    // Coupling or bias coefficient
    typedef logic signed [`ISING_COEF_W-1:0] coef_t;

    // Energy and partial sums
    // Worst case 36*128 stays well inside 16 bits
    typedef logic signed [`ISING_ENERGY_W-1:0] energy_t;

    // Pair index, lexicographic over i<j
    // (0,1)=0 ... (0,7)=6, (1,2)=7 ... (6,7)=27
    typedef logic [$clog2(`ISING_NUM_PAIR)-1:0] pair_idx_t;

    // Index of a single spin
    typedef logic [$clog2(`ISING_NUM_SPIN)-1:0] spin_idx_t;

    // FIFO occupancy, needs to hold 0 up to the full depth
    typedef logic [$clog2(`ISING_SPIN_DEPTH+1)-1:0] fifo_usage_t;

endpackage

// ==== include/ising_defines.svh ====
`ifndef ISING_DEFINES_SVH
`define ISING_DEFINES_SVH

// Spins per configuration vector
`define ISING_NUM_SPIN 8

// Entries in the spin FIFO
`define ISING_SPIN_DEPTH 4

// Signed width of one J or h coefficient
`define ISING_COEF_W 8

// Signed width of energies and partial sums
`define ISING_ENERGY_W 16

// Distinct spin pairs, 8*7/2
`define ISING_NUM_PAIR 28

`endif
